/* sim.f */
hdl/sdramPkg.sv
hdl/sdramCtrl.sv
hdl/burstWriter.sv
hdl/burstReader.sv
hdl/sdramSubsys.sv
tb/sdramModel.sv
tb/sdramCtrl_properties.sv
tb/tbSdramSubsys.sv

/* Makefile */
TOP := tbSdramSubsys
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir $(LOG)

/* tb/tbSdramSubsys.sv */
// random runs from seed 32'hd047 checked against a trace-fed word array; addresses stay below the wrap
`timescale 1ns/10ps
`default_nettype none

module tbSdramSubsys import sdramPkg::*; ();

	logic             clk, rstN;
	logic             wrStart, rdStart, wrDone, rdDone, rdWordValid;
	logic [addrW-1:0] wrBase, rdBase, traceAddr, expAddr;
	logic [cntW-1:0]  wrCount, rdCount;
	logic [dataW-1:0] wrFirst, rdWord, dqIn, expWord, expData;
	sdramPinsT        pins, tracePins;
	int               modelErrors;

	logic [dataW-1:0] refMem [logic [addrW-1:0]]; // every word written so far
	logic [dataW-1:0] expQ[$];                    // expected returns in READ order
	logic [addrW-1:0] wrAddrQ[$];                 // expected WRITE addresses in launch order
	logic [dataW-1:0] wrDataQ[$];                 // pattern word for each of them
	logic [dataW-1:0] gotWords[$];
	logic [addrW-1:0] readAddrs[$];
	int    errors = 0, ruleErrors = 0, tests = 0, passed = 0, testBase = 0;
	int    wordBudget = 0, cycleCount = 0, activeCount = 0;
	int    wrDones = 0, rdDones = 0, readsLeft = 0, earlyWrites = 0;
	logic  rowActive = 1'b0, watchPriority = 1'b0;
	string testName = "reset";

	sdramSubsys u_dut (
		.clk(clk), .rstN(rstN),
		.wrStart(wrStart), .wrBase(wrBase), .wrCount(wrCount), .wrFirst(wrFirst), .wrDone(wrDone),
		.rdStart(rdStart), .rdBase(rdBase), .rdCount(rdCount),
		.rdWord(rdWord), .rdWordValid(rdWordValid), .rdDone(rdDone),
		.dqIn(dqIn), .pins(pins)
	);

	sdramModel u_model (
		.clk(clk), .armed(rstN), .pins(pins), .dqIn(dqIn),
		.tracePins(tracePins), .traceAddr(traceAddr), .errCount(modelErrors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// limit grows with every launched run
	initial begin
		while (cycleCount <= wordBudget * 8 + 1000) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, a done pulse never arrived", cycleCount);
		$display("Errors found");
		$finish;
	end

	task automatic mismatch(input string what, input int expVal, input int actVal);
		errors++;
		$display("FAILED %s, %s: expected %h, actual %h", testName, what, expVal, actVal);
	endtask

	task automatic flagRule(input string what);
		errors++;
		ruleErrors++;
		$display("command rule broken during %s: %s", testName, what);
	endtask

	////////////////////////////////////////////////////////////
	// trace monitor, reference array and returned words
	always @(posedge clk) begin
		if (rstN) begin
			case (tracePins.cmd)
				nop: ;
				active: begin
					if (rowActive)
						flagRule("ACTIVE issued before the previous row was precharged");
					rowActive = 1'b1;
					activeCount++;
				end
				precharge: begin
					if (!rowActive)
						flagRule("PRECHARGE issued with no row open");
					if (!tracePins.addr[10])
						flagRule("PRECHARGE with A10 low, not an all-bank precharge");
					rowActive = 1'b0;
				end
				read: begin
					expQ.push_back(refMem.exists(traceAddr) ? refMem[traceAddr] : 'x);
					readAddrs.push_back(traceAddr);
					if (watchPriority)
						readsLeft--;
				end
				write: begin
					if (wrAddrQ.size() == 0) begin
						errors++;
						$display("WRITE at %h with no launched word left to write", traceAddr);
					end else begin
						expAddr = wrAddrQ.pop_front();
						expData = wrDataQ.pop_front();
						if (traceAddr !== expAddr)
							mismatch("write address", expAddr, traceAddr);
						if (tracePins.dq !== expData)
							mismatch("write data", expData, tracePins.dq);
						refMem[expAddr] = expData; // array as of this command
					end
					if (watchPriority && readsLeft > 0)
						earlyWrites++;
				end
				default: flagRule("command code outside nop, active, read, write, precharge");
			endcase
			if (rdWordValid) begin
				if (expQ.size() == 0) begin
					errors++;
					$display("word %h returned with no READ outstanding", rdWord);
				end else begin
					expWord = expQ.pop_front();
					if (rdWord !== expWord)
						mismatch("returned word", expWord, rdWord);
					gotWords.push_back(rdWord);
				end
			end
			if (wrDone)
				wrDones++;
			if (rdDone)
				rdDones++;
		end
	end

	////////////////////////////////////////////////////////////
	// host drivers, all starting 1 ns after an edge
	task automatic launchWrite(input int base, input int cnt, input int first);
		wrBase     = addrW'(base);
		wrCount    = cntW'(cnt);
		wrFirst    = dataW'(first);
		wrStart    = 1'b1;
		wordBudget += cnt;
		for (int i = 0; i < cnt; i++) begin
			wrAddrQ.push_back(addrW'(base + i)); // one WRITE per address, in order
			wrDataQ.push_back(dataW'(first + i));
		end
		@(posedge clk);
		#1 wrStart = 1'b0;
	endtask

	task automatic launchRead(input int base, input int cnt);
		rdBase     = addrW'(base);
		rdCount    = cntW'(cnt);
		rdStart    = 1'b1;
		wordBudget += cnt;
		@(posedge clk);
		#1 rdStart = 1'b0;
	endtask

	task automatic awaitWrite();
		do
			@(posedge clk);
		while (!wrDone);
		#1;
	endtask

	task automatic awaitRead();
		do
			@(posedge clk);
		while (!rdDone);
		#1;
	endtask

	task automatic fillRun(input int base, input int cnt, input int first);
		launchWrite(base, cnt, first);
		awaitWrite();
		repeat (6) @(posedge clk); // trace lags the pins by a few edges
		#1;
	endtask

	task automatic readRun(input int base, input int cnt);
		gotWords.delete();
		readAddrs.delete();
		launchRead(base, cnt);
		awaitRead();
	endtask

	// incrementing pattern from first, in address order
	task automatic checkPattern(input int base, input int cnt, input int first);
		if (gotWords.size() != cnt)
			mismatch("word count", cnt, gotWords.size());
		for (int i = 0; i < gotWords.size() && i < cnt; i++) begin
			if (gotWords[i] !== dataW'(first + i))
				mismatch("word", dataW'(first + i), gotWords[i]);
			if (readAddrs[i] !== addrW'(base + i))
				mismatch("read address", base + i, readAddrs[i]);
		end
	endtask

	// bank and row sit above the column bits
	function automatic int rowsCovered(input int base, input int cnt);
		return ((base + cnt - 1) >> colW) - (base >> colW) + 1;
	endfunction

	task automatic startTest(input string name);
		testName = name;
		testBase = errors;
	endtask

	task automatic endTest();
		tests++;
		if (errors == testBase) begin
			passed++;
			$display("%s: passed", testName);
		end else
			$display("%s: failed, %0d errors", testName, errors - testBase);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	initial begin
		int base, cnt, first, acts, wrMark, rdMark;
		void'($urandom(32'hd047));
		rstN    = 1'b0;
		wrStart = 1'b0;
		wrBase  = '0;
		wrCount = '0;
		wrFirst = '0;
		rdStart = 1'b0;
		rdBase  = '0;
		rdCount = '0;
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
		@(posedge clk);
		#1;

		startTest("fill and read back");
		base  = $urandom_range(20'hFFC00);
		cnt   = $urandom_range(256, 1);
		first = $urandom_range(16'hFFFF);
		fillRun(base, cnt, first);
		readRun(base, cnt);
		checkPattern(base, cnt, first);
		endTest();

		startTest("row crossing");
		base  = ($urandom_range(4000) << colW) + 256 - $urandom_range(16, 1); // near a row end
		cnt   = 256 - (base % 256) + $urandom_range(40, 1);
		first = $urandom_range(16'hFFFF);
		acts  = activeCount;
		fillRun(base, cnt, first);
		if (activeCount - acts != rowsCovered(base, cnt))
			mismatch("ACTIVE count of write run", rowsCovered(base, cnt), activeCount - acts);
		acts = activeCount;
		readRun(base, cnt);
		if (activeCount - acts != rowsCovered(base, cnt))
			mismatch("ACTIVE count of read run", rowsCovered(base, cnt), activeCount - acts);
		checkPattern(base, cnt, first);
		endTest();

		startTest("read priority");
		base  = $urandom_range(20'h7FC00);
		cnt   = $urandom_range(256, 64);
		first = $urandom_range(16'hFFFF);
		fillRun(base, cnt, first);
		gotWords.delete();
		readAddrs.delete();
		watchPriority = 1'b1;
		readsLeft     = cnt;
		earlyWrites   = 0;
		fork
			launchWrite(base + 20'h80000, cnt, first ^ 16'h5a5a); // other bank
			launchRead(base, cnt);
		join
		fork
			awaitWrite();
			awaitRead();
		join
		watchPriority = 1'b0;
		if (earlyWrites != 0) begin
			errors++;
			$display("%0d WRITE commands appeared before the last READ", earlyWrites);
		end
		checkPattern(base, cnt, first);
		repeat (6) @(posedge clk);
		#1;
		readRun(base + 20'h80000, cnt);
		checkPattern(base + 20'h80000, cnt, first ^ 16'h5a5a);
		endTest();

		startTest("random mixed traffic");
		base = $urandom_range(20'hFF000);
		fillRun(base, 256, $urandom_range(16'hFFFF)); // 512-word window, all written
		fillRun(base + 256, 256, $urandom_range(16'hFFFF));
		wrMark = wrDones;
		rdMark = rdDones;
		fork
			begin
				int wOff, wCnt, wGap;
				repeat (10) begin
					wCnt = $urandom_range(64, 1);
					wOff = $urandom_range(512 - wCnt);
					wGap = $urandom_range(7);
					repeat (wGap) begin
						@(posedge clk);
						#1;
					end
					launchWrite(base + wOff, wCnt, $urandom_range(16'hFFFF));
					awaitWrite();
				end
			end
			begin
				int rOff, rCnt, rGap;
				repeat (10) begin
					rCnt = $urandom_range(64, 1);
					rOff = $urandom_range(512 - rCnt);
					rGap = $urandom_range(7);
					repeat (rGap) begin
						@(posedge clk);
						#1;
					end
					launchRead(base + rOff, rCnt);
					awaitRead();
				end
			end
		join
		repeat (6) @(posedge clk);
		#1;
		if (wrDones - wrMark != 10)
			mismatch("writer done pulses", 10, wrDones - wrMark);
		if (rdDones - rdMark != 10)
			mismatch("reader done pulses", 10, rdDones - rdMark);
		if (expQ.size() != 0)
			mismatch("READs left without a returned word", 0, expQ.size());
		if (wrAddrQ.size() != 0)
			mismatch("launched words never written", 0, wrAddrQ.size());
		endTest();

		// standing check over the whole run
		testName = "precharge rule";
		if (rowActive)
			flagRule("a row was left open at the end");
		tests++;
		if (ruleErrors == 0) begin
			passed++;
			$display("%s: passed", testName);
		end else
			$display("%s: failed, %0d errors", testName, ruleErrors);

		errors += modelErrors;
		$display("%0d of %0d tests passed, %0d errors, %0d from the SDRAM model",
			passed, tests, errors, modelErrors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/sdramCtrl_properties.sv */
// command stream rules on the controller pins, sampled at the rising clock edge
`timescale 1ns/10ps
`default_nettype none

module sdramCtrlProperties import sdramPkg::*; (
	input wire logic      clk,
	input wire logic      rstN,
	input wire sdramPinsT pins
);

	// reset leaves the part idle with both bytes masked
	resetIdle: assert property (@(posedge clk)
		$rose(rstN) |-> (pins.cmd == nop && pins.dqm == 2'b11))
		else $error("pins not idle with masks high in the first cycle after reset");

	// data bus driven only under a write command
	driveOnWrite: assert property (@(posedge clk) disable iff (!rstN)
		pins.dqOe |-> pins.cmd == write)
		else $error("write data enabled under a non-write command");

	// an opened row is used in the very next cycle
	activeThenAccess: assert property (@(posedge clk) disable iff (!rstN)
		pins.cmd == active |=> pins.cmd inside {read, write})
		else $error("ACTIVE not followed by READ or WRITE");

	prechargeThenNop: assert property (@(posedge clk) disable iff (!rstN)
		pins.cmd == precharge |=> pins.cmd == nop)
		else $error("PRECHARGE not followed by NOP");

endmodule

bind sdramCtrl sdramCtrlProperties u_props (.clk(clk), .rstN(rstN), .pins(pins));

`default_nettype wire

/* tb/sdramModel.sv */
// behavioral two-bank CL2 part; models open rows and written words only, no timing or refresh checks
`timescale 1ns/10ps
`default_nettype none

module sdramModel import sdramPkg::*; (
	input  wire logic        clk,
	input  wire logic        armed,     // checks off while the controller sits in reset
	input  wire sdramPinsT   pins,
	output logic [dataW-1:0] dqIn,
	output sdramPinsT        tracePins, // pins as sampled at the last edge
	output logic [addrW-1:0] traceAddr, // full word address behind that read or write
	output int               errCount
);

	logic [dataW-1:0] mem [logic [addrW-1:0]]; // only written words exist
	logic [1:0]       rowOpen = 2'b00;
	logic [rowW-1:0]  openRow [2];
	logic [dataW-1:0] casStage = '0;          // first CAS latency stage
	logic [dataW-1:0] dqOut = '0;
	int               errs = 0;
	sdramAddrU        colAddr;

	// column command plus the row opened in its bank gives the word address
	assign colAddr.linear = {pins.bank, openRow[pins.bank], pins.addr[colW-1:0]};
	assign dqIn           = dqOut;
	assign errCount       = errs;

	////////////////////////////////////////////////////////////
	// command decode at each rising edge
	always @(posedge clk) begin
		tracePins <= pins;
		traceAddr <= colAddr.linear;
		casStage  <= 'x;       // bus floats unless a read is in progress
		dqOut     <= casStage; // word reaches dq two edges after READ
		if (armed) begin
			case (pins.cmd)
				active: begin
					if (rowOpen[pins.bank]) begin
						errs <= errs + 1;
						$display("model: ACTIVE to bank %0d while row %h is still open",
							pins.bank, openRow[pins.bank]);
					end
					rowOpen[pins.bank] <= 1'b1;
					openRow[pins.bank] <= pins.addr;
				end
				read: begin
					if (!rowOpen[pins.bank]) begin
						errs <= errs + 1;
						$display("model: READ to bank %0d with no open row", pins.bank);
					end else if (pins.dqm != 2'b00) begin
						errs <= errs + 1;
						$display("model: READ at %h with byte masks %b set", colAddr.linear,
							pins.dqm);
					end else if (!mem.exists(colAddr.linear)) begin
						errs <= errs + 1;
						$display("model: READ of unwritten word at %h", colAddr.linear);
					end else
						casStage <= mem[colAddr.linear];
				end
				write: begin
					if (!rowOpen[pins.bank]) begin
						errs <= errs + 1;
						$display("model: WRITE to bank %0d with no open row", pins.bank);
					end else if (!pins.dqOe) begin
						errs <= errs + 1;
						$display("model: WRITE at %h with the data bus not driven", colAddr.linear);
					end else if (pins.dqm != 2'b00) begin
						errs <= errs + 1;
						$display("model: WRITE at %h with byte masks %b set", colAddr.linear,
							pins.dqm);
					end else
						mem[colAddr.linear] = pins.dq;
				end
				precharge: begin
					if (pins.addr[10])
						rowOpen <= 2'b00; // all banks
					else
						rowOpen[pins.bank] <= 1'b0;
				end
				default: ; // nop, other codes are the testbench's concern
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/sdramSubsys.sv */
// one writer and one reader sharing a CL2 SDRAM; dq is split into out word, enable and in word
`timescale 1ns/10ps
`default_nettype none

module sdramSubsys import sdramPkg::*; (
	input  wire logic             clk,
	input  wire logic             rstN,
	// writer host
	input  wire logic             wrStart,
	input  wire logic [addrW-1:0] wrBase,
	input  wire logic [cntW-1:0]  wrCount,
	input  wire logic [dataW-1:0] wrFirst,
	output logic                  wrDone,
	// reader host
	input  wire logic             rdStart,
	input  wire logic [addrW-1:0] rdBase,
	input  wire logic [cntW-1:0]  rdCount,
	output logic [dataW-1:0]      rdWord,
	output logic                  rdWordValid,
	output logic                  rdDone,
	// SDRAM
	input  wire logic [dataW-1:0] dqIn,
	output sdramPinsT             pins
);

	////////////////////////////////////////////////////////////
	// agent to controller
	logic             rdReq, rdGnt, rdDataValid;
	sdramAddrU        rdAddr;
	logic [dataW-1:0] rdData;
	logic             wrReq, wrGnt;
	sdramAddrU        wrAddr;
	logic [dataW-1:0] wrData;

	burstWriter u_writer (
		.clk(clk), .rstN(rstN),
		.start(wrStart), .baseAddr(wrBase), .count(wrCount), .firstData(wrFirst),
		.done(wrDone),
		.wrGnt(wrGnt), .wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData)
	);

	burstReader u_reader (
		.clk(clk), .rstN(rstN),
		.start(rdStart), .baseAddr(rdBase), .count(rdCount),
		.rdWord(rdWord), .rdWordValid(rdWordValid), .done(rdDone),
		.rdGnt(rdGnt), .rdData(rdData), .rdDataValid(rdDataValid),
		.rdReq(rdReq), .rdAddr(rdAddr)
	);

	sdramCtrl u_ctrl (
		.clk(clk), .rstN(rstN),
		.rdReq(rdReq), .rdAddr(rdAddr), .rdGnt(rdGnt),
		.rdData(rdData), .rdDataValid(rdDataValid),
		.wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData), .wrGnt(wrGnt),
		.dqIn(dqIn), .pins(pins)
	);

endmodule

`default_nettype wire

/* hdl/burstReader.sv */
// read agent for runs of 0 to 256 words; returned words pass straight through with their valid
`timescale 1ns/10ps
`default_nettype none

module burstReader import sdramPkg::*; (
	input  wire logic             clk,
	input  wire logic             rstN,
	// host side
	input  wire logic             start,
	input  wire logic [addrW-1:0] baseAddr,
	input  wire logic [cntW-1:0]  count,
	output logic [dataW-1:0]      rdWord,
	output logic                  rdWordValid,
	output logic                  done,
	// controller side
	input  wire logic             rdGnt,
	input  wire logic [dataW-1:0] rdData,
	input  wire logic             rdDataValid,
	output logic                  rdReq,
	output sdramAddrU             rdAddr
);

	logic               busy;      // from start until the last word is back
	logic [cntW-1:0]    remaining; // addresses not yet granted
	logic [flightW-1:0] inFlight;  // granted minus returned
	logic               load;

	assign load = start & ~busy;

	////////////////////////////////////////////////////////////
	// run control
	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy      <= 1'b0;
			rdReq     <= 1'b0;
			remaining <= '0;
			inFlight  <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (load) begin
				remaining <= count;
				rdReq     <= (count != '0);
				busy      <= (count != '0);
				done      <= (count == '0); // nothing to fetch
			end else if (busy) begin
				if (rdGnt) begin
					remaining <= remaining - 1'b1;
					if (remaining == cntW'(1))
						rdReq <= 1'b0; // all addresses issued
				end
				inFlight <= inFlight + flightW'(rdGnt) - flightW'(rdDataValid);
				// last outstanding word leaves this cycle
				if (!rdReq && rdDataValid && inFlight == flightW'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// next address to request
	always_ff @(posedge clk) begin
		if (load)
			rdAddr.linear <= baseAddr;
		else if (rdGnt)
			rdAddr.linear <= rdAddr.linear + 1'b1;
	end

	assign rdWord      = rdData;
	assign rdWordValid = rdDataValid & busy; // words only belong to a running burst

endmodule

`default_nettype wire

/* hdl/burstWriter.sv */
// write agent for runs of 0 to 256 words; the address wraps at the top of memory
`timescale 1ns/10ps
`default_nettype none

module burstWriter import sdramPkg::*; (
	input  wire logic             clk,
	input  wire logic             rstN,
	// host side
	input  wire logic             start,
	input  wire logic [addrW-1:0] baseAddr,
	input  wire logic [cntW-1:0]  count,
	input  wire logic [dataW-1:0] firstData,
	output logic                  done,
	// controller side
	input  wire logic             wrGnt,
	output logic                  wrReq,
	output sdramAddrU             wrAddr,
	output logic [dataW-1:0]      wrData
);

	logic [cntW-1:0] remaining; // words not yet granted
	logic            load;

	assign load = start & ~wrReq; // start while busy is dropped

	////////////////////////////////////////////////////////////
	// run control
	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrReq     <= 1'b0;
			remaining <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0; // single pulse
			if (load) begin
				remaining <= count;
				wrReq     <= (count != '0);
				done      <= (count == '0); // empty run ends at once
			end else if (wrGnt) begin
				remaining <= remaining - 1'b1;
				if (remaining == cntW'(1)) begin
					wrReq <= 1'b0; // last word granted
					done  <= 1'b1;
				end
			end
		end
	end

	// address and pattern, both step on every grant
	always_ff @(posedge clk) begin
		if (load) begin
			wrAddr.linear <= baseAddr;
			wrData        <= firstData;
		end else if (wrGnt) begin
			wrAddr.linear <= wrAddr.linear + 1'b1;
			wrData        <= wrData + 1'b1; // incrementing pattern
		end
	end

endmodule

`default_nettype wire

/* hdl/sdramCtrl.sv */
// open-row controller for CL2; reads beat writes, a row stays open only for the agent that opened it
`timescale 1ns/10ps
`default_nettype none

module sdramCtrl import sdramPkg::*; (
	input  wire logic             clk,
	input  wire logic             rstN,
	// read agent
	input  wire logic             rdReq,
	input  wire sdramAddrU        rdAddr,
	output logic                  rdGnt,
	output logic [dataW-1:0]      rdData,
	output logic                  rdDataValid,
	// write agent
	input  wire logic             wrReq,
	input  wire sdramAddrU        wrAddr,
	input  wire logic [dataW-1:0] wrData,
	output logic                  wrGnt,
	// SDRAM side
	input  wire logic [dataW-1:0] dqIn,
	output sdramPinsT             pins
);

	logic [1:0]           state;
	logic                 readSel;    // agent owning the open row, latched in idle
	logic                 readCycle;  // agent whose address is looked at this cycle
	logic                 canOpen;    // no precharge on the pins right now
	logic                 anyReq;
	logic                 sameRow;    // bank and row match the last granted access
	logic                 granted;
	sdramAddrU            addr;
	sdramAddrU            addrR;      // address of the previous cycle's grant
	logic [dataW-1:0]     wrData1;    // first write data stage
	logic [rdLatency-1:0] validPipe;  // read grant flags on their way to rdDataValid

	////////////////////////////////////////////////////////////
	// arbitration
	assign canOpen   = (pins.cmd != precharge); // keep a nop after every precharge
	assign anyReq    = rdReq | wrReq;
	assign readCycle = (state == stIdle) ? rdReq : readSel; // read priority when idle
	assign addr      = readCycle ? rdAddr : wrAddr;
	assign sameRow   = ({addr.f.bank, addr.f.row} == {addrR.f.bank, addrR.f.row});

	assign rdGnt = ((state == stIdle) & canOpen & rdReq) |
		((state == stAccess) & readSel & rdReq & sameRow);
	assign wrGnt = ((state == stIdle) & canOpen & ~rdReq & wrReq) |
		((state == stAccess) & ~readSel & wrReq & sameRow);
	assign granted = rdGnt | wrGnt;

	////////////////////////////////////////////////////////////
	// command sequencer, pins registered
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state   <= stIdle;
			readSel <= 1'b0;
			pins    <= pinsIdle; // nop, masks high, bus released
		end else begin
			case (state)
				stIdle: begin
					readSel <= rdReq; // remembered for the whole open row
					if (canOpen && anyReq) begin
						pins.cmd  <= active;
						pins.bank <= addr.f.bank;
						pins.addr <= addr.f.row;
						pins.dqm  <= 2'b11;
						pins.dqOe <= 1'b0;
						state     <= stAccess;
					end else begin
						pins.cmd  <= nop;
						pins.bank <= 1'b0;
						pins.addr <= '0;
						pins.dqm  <= 2'b11;
						pins.dqOe <= 1'b0;
					end
				end
				stAccess: begin
					// column access for the grant one cycle back
					pins.cmd  <= readSel ? read : write;
					pins.bank <= addrR.f.bank;
					pins.addr <= {{(rowW-colW){1'b0}}, addrR.f.col}; // A10 low, no auto-precharge
					pins.dqm  <= 2'b00;
					pins.dqOe <= ~readSel;
					pins.dq   <= wrData1; // second write data stage
					if (!granted)
						state <= stPrecharge; // run left the row or stopped
				end
				stPrecharge: begin
					pins.cmd  <= precharge;
					pins.bank <= 1'b0;
					pins.addr <= prechargeAll;
					pins.dqm  <= 2'b11;
					pins.dqOe <= 1'b0;
					state     <= stIdle;
				end
				default: begin
					pins.cmd  <= nop;
					pins.dqOe <= 1'b0;
					state     <= stIdle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// datapath stages
	always_ff @(posedge clk) begin
		addrR   <= addr;   // compared against next cycle's request
		wrData1 <= wrData; // lines up with the write command two cycles on
		rdData  <= dqIn;   // captured every cycle, qualified by validPipe
	end

	// grant, two command stages, CAS latency, capture
	always_ff @(posedge clk) begin
		if (!rstN)
			validPipe <= '0;
		else
			validPipe <= {validPipe[rdLatency-2:0], rdGnt};
	end

	assign rdDataValid = validPipe[rdLatency-1];

endmodule

`default_nettype wire

/* hdl/sdramPkg.sv */
// assumes a 1M x 16 two-bank SDRAM already loaded with CAS latency 2; no refresh is ever issued
`default_nettype none

package sdramPkg;

	////////////////////////////////////////////////////////////
	// geometry and latency
	localparam int addrW      = 20;              // linear word address, 1M words
	localparam int dataW      = 16;              // one SDRAM word
	localparam int rowW       = 11;              // row bits, also the pin address bus width
	localparam int colW       = 8;               // 256 words per row
	localparam int cntW       = colW + 1;        // run length up to 256
	localparam int casLatency = 2;
	// two command stages, the CAS delay, then one capture register
	localparam int rdLatency  = casLatency + 3;
	localparam int flightW    = $clog2(rdLatency + 2); // reads outstanding at the reader

	// controller sequencer states
	localparam logic [1:0] stIdle      = 2'd0;
	localparam logic [1:0] stAccess    = 2'd1;
	localparam logic [1:0] stPrecharge = 2'd2;

	localparam logic [rowW-1:0] prechargeAll = 11'h400; // A10 high selects all banks

	////////////////////////////////////////////////////////////
	// command code is {rasN, casN, weN}
	typedef enum logic [2:0] {
		loadMode  = 3'b000,
		refresh   = 3'b001,
		precharge = 3'b010,
		active    = 3'b011,
		write     = 3'b100,
		read      = 3'b101,
		nop       = 3'b111
	} sdramCmdE;

	// one address word, seen linear by the agents and split by the controller
	typedef union packed {
		logic [addrW-1:0] linear;
		struct packed {
			logic            bank; // top bit picks one of two banks
			logic [rowW-1:0] row;
			logic [colW-1:0] col;
		} f;
	} sdramAddrU;

	// everything the controller drives toward the part, all registered
	typedef struct packed {
		sdramCmdE         cmd;
		logic [rowW-1:0]  addr;  // row on active, column on read/write
		logic             bank;
		logic [1:0]       dqm;   // byte masks, high masks the byte
		logic [dataW-1:0] dq;    // write word
		logic             dqOe;  // write word drives the bus
	} sdramPinsT;

	localparam sdramPinsT pinsIdle = '{
		cmd: nop, addr: '0, bank: 1'b0, dqm: 2'b11, dq: '0, dqOe: 1'b0
	};

endpackage

`default_nettype wire
